//--- Makefile
# Verilator build and run for the peripheral matrix testbench

VERILATOR ?= verilator
TOP       ?= tbSmMatrix
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASSMSG   ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: $(SIMBIN)
	@out="$$(./$(SIMBIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)

//--- bench/alsSensorModel.sv
`timescale 1ns/100ps

module alsSensorModel (
    input  logic       cs,
    input  logic       sck,
    input  logic [7:0] sample,   // light level reported in the next frame
    output logic       sdo
);

    localparam int unsigned frameBits = 16;
    localparam int unsigned leadBits  = 3;                        // zeros ahead of the sample
    localparam int unsigned tailBits  = frameBits - leadBits - 8;  // zeros after it

    logic [frameBits-1:0] frame;   // bits not yet on the wire
    logic                 outBit;  // bit on the wire

    initial begin
        frame  = '0;
        outBit = 1'b0;
    end

    // new frame when cs falls while sck is parked high
    // each falling sck puts the next bit out for the master's rising edge
    always @(negedge cs or negedge sck) begin
        if (sck) begin
            frame  <= frameBits'(sample) << tailBits;
            outBit <= 1'b0;
        end else if (!cs) begin
            outBit <= frame[frameBits-1];
            frame  <= {frame[frameBits-2:0], 1'b0};
        end
    end

    assign sdo = cs ? 1'b0 : outBit;  // quiet while deselected

endmodule : alsSensorModel

//--- bench/tbSmMatrix.sv
`timescale 1ns/100ps

module tbSmMatrix;

    localparam int unsigned gpioWidth     = 8;
    localparam int unsigned pwmPeriod     = 256;  // 2**pwmWidth with default width
    localparam int unsigned drvDelay      = 10;   // inputs change this long after the edge
    localparam int unsigned sampleDelay   = 30;   // read data taken this long after driving
    localparam int unsigned gpioPollLimit = 8;
    localparam int unsigned alsPollLimit  = 400;  // a bit under three frames

    localparam logic [31:0] gpioInAddr   = 32'h0000_7f00;
    localparam logic [31:0] gpioOutAddr  = 32'h0000_7f04;
    localparam logic [31:0] pwmAddr      = 32'h0000_7f10;
    localparam logic [31:0] alsAddr      = 32'h0000_7f20;
    localparam logic [31:0] freshFlag    = 32'h0000_0100;
    localparam logic [7:0]  firstSample  = 8'h5a;
    localparam logic [7:0]  secondSample = 8'hc7;

    typedef enum logic [2:0] {
        opWrite,
        opRead,   // read and compare
        opPins,   // set GPIO pins, or the sensor sample for the ALS address
        opPoll,   // read until expected, data holds the only other legal value
        opPwm     // count high cycles over one period
    } opKindT;

    typedef struct packed {
        opKindT      kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
    } stepT;

    logic                 clk;
    logic                 rst;
    logic [31:0]          bAddr;
    logic                 bWrite;
    logic [31:0]          bWData;
    logic [31:0]          bRData;
    logic [gpioWidth-1:0] gpioInput;
    logic [gpioWidth-1:0] gpioOutput;
    logic                 pwmOutput;
    logic                 alsCS;
    logic                 alsSCK;
    logic                 alsSDO;
    logic [7:0]           sensorSample;

    stepT steps[$];
    int   errors;
    int   timeouts;

    smMatrix u_smMatrix (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .bAddr      ( bAddr      ),
        .bWrite     ( bWrite     ),
        .bWData     ( bWData     ),
        .bRData     ( bRData     ),
        .gpioInput  ( gpioInput  ),
        .gpioOutput ( gpioOutput ),
        .pwmOutput  ( pwmOutput  ),
        .alsCS      ( alsCS      ),
        .alsSCK     ( alsSCK     ),
        .alsSDO     ( alsSDO     )
    );

    alsSensorModel sensor (
        .cs     ( alsCS        ),
        .sck    ( alsSCK       ),
        .sample ( sensorSample ),
        .sdo    ( alsSDO       )
    );

    always #50 clk = ~clk;  // 100 ns period

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void addStep(input opKindT kind, input logic [31:0] addr,
                                    input logic [31:0] data, input logic [31:0] expected);
        steps.push_back('{kind, addr, data, expected});
    endfunction

    task automatic buildTable();
        logic [31:0] seed;
        logic [31:0] word [4];
        logic [31:0] ramAddr [4];
        logic [31:0] pwmLevel [3];
        seed     = 32'h6092a0da;
        ramAddr  = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0100, 32'h0000_03fc};
        pwmLevel = '{32'd0, 32'd100, 32'd255};
        // sensor first, so the first poll really waits for a frame
        addStep(opPoll, alsAddr, 32'h0, freshFlag | 32'(firstSample));
        addStep(opPins, alsAddr, 32'(secondSample), 32'h0);
        addStep(opPoll, alsAddr, freshFlag | 32'(firstSample), freshFlag | 32'(secondSample));
        for (int i = 0; i < 4; i++) begin
            seed    = lcgStep(seed);
            word[i] = seed;
            addStep(opWrite, ramAddr[i], word[i], 32'h0);
        end
        for (int i = 0; i < 4; i++) addStep(opRead, ramAddr[i], 32'h0, word[i]);
        seed    = lcgStep(seed);
        word[2] = seed;                                  // overwrite one word only
        addStep(opWrite, ramAddr[2], word[2], 32'h0);
        for (int i = 0; i < 4; i++) addStep(opRead, ramAddr[i], 32'h0, word[i]);
        addStep(opWrite, gpioOutAddr, 32'hffff_ffa5, 32'h0000_00a5);
        addStep(opRead, gpioOutAddr, 32'h0, 32'h0000_00a5);
        addStep(opPins, gpioInAddr, 32'h0000_003c, 32'h0);
        addStep(opPoll, gpioInAddr, 32'h0, 32'h0000_003c);
        addStep(opPins, gpioInAddr, 32'h0000_00c3, 32'h0);
        addStep(opPoll, gpioInAddr, 32'h0000_003c, 32'h0000_00c3);
        for (int i = 0; i < 3; i++) begin
            addStep(opWrite, pwmAddr, pwmLevel[i], 32'h0);
            addStep(opRead, pwmAddr, 32'h0, pwmLevel[i]);
            addStep(opPwm, pwmAddr, 32'h0, pwmLevel[i]);
        end
        // unmapped space
        addStep(opRead, 32'h0000_7f40, 32'h0, 32'h0);
        addStep(opRead, 32'h0000_8000, 32'h0, 32'h0);
        addStep(opRead, 32'h0000_4000, 32'h0, 32'h0);
        addStep(opWrite, 32'h0000_8000, 32'hdead_beef, 32'h0);
        addStep(opWrite, 32'h0000_7f40, 32'h1234_5678, 32'h0);
        for (int i = 0; i < 4; i++) addStep(opRead, ramAddr[i], 32'h0, word[i]);
        addStep(opRead, gpioOutAddr, 32'h0, 32'h0000_00a5);
        addStep(opRead, pwmAddr, 32'h0, 32'h0000_00ff);
    endtask

    task automatic checkValue(input logic [31:0] addr, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] t=%0t addr %08h expected %08h got %08h",
                     $time, addr, expected, actual);
        end
    endtask

    task automatic busRead(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #drvDelay;
        bAddr  = addr;
        bWrite = 1'b0;
        #sampleDelay;
        data = bRData;  // combinational, settled well before the next edge
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] pinValue);
        @(posedge clk);
        #drvDelay;
        bAddr  = addr;
        bWrite = 1'b1;
        bWData = data;
        @(posedge clk);  // write commits here
        #drvDelay;
        bWrite = 1'b0;
        if (addr == gpioOutAddr) checkValue(addr, pinValue, 32'(gpioOutput));
    endtask

    task automatic setPins(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #drvDelay;
        if (addr == alsAddr) begin
            sensorSample = data[7:0];
        end else begin
            gpioInput = data[gpioWidth-1:0];
        end
    endtask

    task automatic pollUntil(input logic [31:0] addr, input logic [31:0] oldValue,
                             input logic [31:0] expected);
        logic [31:0] data;
        int unsigned limit;
        int unsigned tries;
        bit          done;
        limit = (addr == alsAddr) ? alsPollLimit : gpioPollLimit;
        tries = 0;
        done  = 1'b0;
        while (!done && tries < limit) begin
            busRead(addr, data);
            tries++;
            if (data === expected) begin
                done = 1'b1;
            end else begin
                checkValue(addr, oldValue, data);  // nothing in between is legal
            end
        end
        if (!done) begin
            timeouts++;
            $display("timeout: read of %08h did not return %08h within %0d cycles",
                     addr, expected, limit);
        end
    endtask

    task automatic measurePwm(input logic [31:0] expected);
        int unsigned high;
        // one period is enough for a wrap to load the new threshold
        repeat (pwmPeriod + 2) @(posedge clk);
        high = 0;
        repeat (pwmPeriod) begin
            @(posedge clk);
            #drvDelay;
            if (pwmOutput) high++;
        end
        checkValue(pwmAddr, expected, 32'(high));
    endtask

    task automatic runStep(input stepT s);
        logic [31:0] data;
        case (s.kind)
            opWrite: busWrite(s.addr, s.data, s.expected);
            opRead: begin
                busRead(s.addr, data);
                checkValue(s.addr, s.expected, data);
            end
            opPins: setPins(s.addr, s.data);
            opPoll: pollUntil(s.addr, s.data, s.expected);
            opPwm: measurePwm(s.expected);
            default: begin
                errors++;
                $display("table holds a step of unknown kind");
            end
        endcase
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        bAddr        = '0;
        bWrite       = 1'b0;
        bWData       = '0;
        gpioInput    = '0;
        sensorSample = firstSample;
        errors       = 0;
        timeouts     = 0;
        buildTable();
        repeat (4) @(posedge clk);
        #drvDelay;
        rst = 1'b0;
        // pin states as they leave reset
        assert (alsCS === 1'b1 && alsSCK === 1'b1 && pwmOutput === 1'b0
                && gpioOutput === '0) else begin
            errors++;
            $display("[ERROR] t=%0t reset state cs %b sck %b pwm %b gpio %h",
                     $time, alsCS, alsSCK, pwmOutput, gpioOutput);
        end
        foreach (steps[i]) runStep(steps[i]);
        repeat (2) @(posedge clk);
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tbSmMatrix

//--- src/smAls.sv
`timescale 1ns/100ps

module smAls #(
    parameter int unsigned alsDivider = 4
) (
    input  logic   clk,
    input  logic   rst,
    smBusIf.target bus,
    output logic   cs,
    output logic   sck,
    input  logic   sdo
);
    import smConfig::*;

    localparam int unsigned divWidth = (alsDivider > 1) ? $clog2(alsDivider) : 1;
    localparam int unsigned cntWidth = $clog2(ALS_FRAME_BITS) + 1;

    typedef enum logic {
        alsIdle,
        alsFrame
    } alsStateT;

    alsStateT                  state;
    logic [divWidth-1:0]       divCnt;
    logic                      halfTick;   // end of one sck half-period
    logic                      sckRise;
    logic [cntWidth-1:0]       bitCnt;     // bits in frame, half-periods in idle
    logic [ALS_FRAME_BITS-1:0] shiftReg;
    logic [ALS_FRAME_BITS-1:0] shiftNext;
    logic [7:0]                value;      // last sample
    logic                      fresh;

    assign halfTick  = (divCnt == divWidth'(alsDivider - 1));
    assign sckRise   = halfTick && (state == alsFrame) && !sck;
    assign shiftNext = {shiftReg[ALS_FRAME_BITS-2:0], sdo};

    always_ff @(posedge clk) begin
        if (rst || halfTick) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // sdo sampled on rising sck, the sensor moves it on falling sck
    always_ff @(posedge clk) begin
        if (sckRise) begin
            shiftReg <= shiftNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= alsIdle;
            cs     <= 1'b1;
            sck    <= 1'b1;
            bitCnt <= '0;
            value  <= '0;
            fresh  <= 1'b0;
        end else if (halfTick) begin
            case (state)
                alsIdle: begin
                    // stay deselected for one full sck period
                    if (bitCnt == cntWidth'(1)) begin
                        state  <= alsFrame;
                        cs     <= 1'b0;
                        bitCnt <= '0;
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                alsFrame: begin
                    sck <= ~sck;
                    if (!sck) begin  // rising edge, one bit taken
                        if (bitCnt == cntWidth'(ALS_FRAME_BITS - 1)) begin
                            state  <= alsIdle;
                            cs     <= 1'b1;
                            bitCnt <= '0;
                            value  <= shiftNext[ALS_DATA_LSB +: 8];
                            fresh  <= 1'b1;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end
                default: state <= alsIdle;
            endcase
        end
    end

    // read only, sample plus fresh flag
    always_comb begin
        bus.rData                = '0;
        bus.rData[7:0]           = value;
        bus.rData[ALS_FRESH_BIT] = fresh;
    end

    // clock parks high whenever the sensor is deselected
    sckIdleHigh: assert property (@(posedge clk) disable iff (rst) cs |-> sck)
        else $error("als: sck low while cs is high");

endmodule : smAls

//--- src/smBusIf.sv
`timescale 1ns/100ps

interface smBusIf ();

    logic        sel;     // this target is addressed
    logic [31:0] addr;    // byte address, full bus copy
    logic        write;   // write strobe, not qualified by sel
    logic [31:0] wData;
    logic [31:0] rData;   // combinational read data from the target

    // router side drives the request and samples read data
    modport router (
        output sel, addr, write, wData,
        input  rData
    );

    // target side, writes only when sel and write are both high
    modport target (
        input  sel, addr, write, wData,
        output rData
    );

endinterface : smBusIf

//--- src/smBusRouter.sv
`timescale 1ns/100ps

module smBusRouter (
    input  logic [31:0] bAddr,
    input  logic        bWrite,
    input  logic [31:0] bWData,
    output logic [31:0] bRData,
    smBusIf.router      ramBus,
    smBusIf.router      gpioBus,
    smBusIf.router      pwmBus,
    smBusIf.router      alsBus
);
    import smConfig::*;

    logic [3:0] sel;  // ram, gpio, pwm, als from bit 0 up

    // decode on the low 16 address bits, upper bits are ignored
    always_comb begin
        sel[0] = (bAddr[15:14] == RAM_ADDR_MATCH);   // 0x0000 - 0x3fff
        sel[1] = (bAddr[15:4]  == GPIO_ADDR_MATCH);  // 0x7f00 - 0x7f0f
        sel[2] = (bAddr[15:4]  == PWM_ADDR_MATCH);   // 0x7f10 - 0x7f1f
        sel[3] = (bAddr[15:4]  == ALS_ADDR_MATCH);   // 0x7f20 - 0x7f2f
    end

    // fan-out, every target sees the full request
    assign ramBus.sel    = sel[0];
    assign ramBus.addr   = bAddr;
    assign ramBus.write  = bWrite;
    assign ramBus.wData  = bWData;

    assign gpioBus.sel   = sel[1];
    assign gpioBus.addr  = bAddr;
    assign gpioBus.write = bWrite;
    assign gpioBus.wData = bWData;

    assign pwmBus.sel    = sel[2];
    assign pwmBus.addr   = bAddr;
    assign pwmBus.write  = bWrite;
    assign pwmBus.wData  = bWData;

    assign alsBus.sel    = sel[3];
    assign alsBus.addr   = bAddr;
    assign alsBus.write  = bWrite;
    assign alsBus.wData  = bWData;

    // read data mux, unmapped space reads as zero
    always_comb begin
        case (sel)
            4'b0001: bRData = ramBus.rData;
            4'b0010: bRData = gpioBus.rData;
            4'b0100: bRData = pwmBus.rData;
            4'b1000: bRData = alsBus.rData;
            default: bRData = '0;
        endcase
    end

    // address windows must never overlap
    selOneHot: assert property (@(bAddr) $onehot0(sel))
        else $error("router: overlapping selects %b", sel);

endmodule : smBusRouter

//--- src/smConfig.sv
package smConfig;

    // address map
    // RAM   0x0000 - 0x3fff, decoded from address bits 15..14
    localparam logic [1:0]  RAM_ADDR_MATCH  = 2'b00;

    // peripheral windows are 16 bytes each, decoded from address bits 15..4
    localparam logic [11:0] GPIO_ADDR_MATCH = 12'h7f0;  // 0x7f00 - 0x7f0f
    localparam logic [11:0] PWM_ADDR_MATCH  = 12'h7f1;  // 0x7f10 - 0x7f1f
    localparam logic [11:0] ALS_ADDR_MATCH  = 12'h7f2;  // 0x7f20 - 0x7f2f

    // GPIO word offsets, taken from address bits 3..2
    localparam logic [1:0]  GPIO_IN_OFFSET  = 2'd0;    // synchronized input pins
    localparam logic [1:0]  GPIO_OUT_OFFSET = 2'd1;    // output register

    // light sensor frame
    // one frame is 16 sck cycles; the sensor sends 3 leading zeros,
    // the 8-bit sample MSB first, then trailing zeros
    localparam int unsigned ALS_FRAME_BITS  = 16;

    // sample LSB position in the shift register once the whole frame is in,
    // frame bit 10 (counted from the first sck) lands here
    localparam int unsigned ALS_DATA_LSB    = 5;

    // read data bit set after the first complete frame
    localparam int unsigned ALS_FRESH_BIT   = 8;

endpackage : smConfig

//--- src/smGpio.sv
`timescale 1ns/100ps

module smGpio #(
    parameter int unsigned gpioWidth = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    smBusIf.target               bus,
    input  logic [gpioWidth-1:0] gpioInput,
    output logic [gpioWidth-1:0] gpioOutput
);
    import smConfig::*;

    logic [gpioWidth-1:0] syncMeta;  // first stage, may go metastable
    logic [gpioWidth-1:0] syncIn;    // second stage, safe to use
    logic                 outWrite;

    assign outWrite = bus.sel && bus.write && (bus.addr[3:2] == GPIO_OUT_OFFSET);

    // output register drives the pins directly
    always_ff @(posedge clk) begin
        if (rst) begin
            gpioOutput <= '0;
        end else if (outWrite) begin
            gpioOutput <= bus.wData[gpioWidth-1:0];
        end
    end

    // two-flop synchronizer for the asynchronous pins
    always_ff @(posedge clk) begin
        syncMeta <= gpioInput;
        syncIn   <= syncMeta;
    end

    // inputs at their offset, output register anywhere else in the window
    always_comb begin
        if (bus.addr[3:2] == GPIO_IN_OFFSET) begin
            bus.rData = 32'(syncIn);
        end else begin
            bus.rData = 32'(gpioOutput);
        end
    end

endmodule : smGpio

//--- src/smMatrix.sv
`timescale 1ns/100ps

module smMatrix #(
    parameter int unsigned gpioWidth  = 8,    // number of GPIO pins
    parameter int unsigned ramDepth   = 256,  // data RAM size in words
    parameter int unsigned pwmWidth   = 8,    // PWM counter width
    parameter int unsigned alsDivider = 4     // clk cycles per sck half-period
) (
    // bus side
    input  logic                 clk,
    input  logic                 rst,
    input  logic [31:0]          bAddr,       // bus address
    input  logic                 bWrite,      // bus write strobe
    input  logic [31:0]          bWData,      // bus write data
    output logic [31:0]          bRData,      // bus read data, same cycle

    // pin side
    input  logic [gpioWidth-1:0] gpioInput,   // GPIO input pins
    output logic [gpioWidth-1:0] gpioOutput,  // GPIO output pins
    output logic                 pwmOutput,   // PWM output pin
    output logic                 alsCS,       // light sensor chip select
    output logic                 alsSCK,      // light sensor SPI clock
    input  logic                 alsSDO       // light sensor SPI data
);

    // one bus bundle per target
    smBusIf ramBus  ();
    smBusIf gpioBus ();
    smBusIf pwmBus  ();
    smBusIf alsBus  ();

    smBusRouter router (
        .bAddr   ( bAddr   ),
        .bWrite  ( bWrite  ),
        .bWData  ( bWData  ),
        .bRData  ( bRData  ),
        .ramBus  ( ramBus  ),
        .gpioBus ( gpioBus ),
        .pwmBus  ( pwmBus  ),
        .alsBus  ( alsBus  )
    );

    // data memory
    smRam #(
        .ramDepth ( ramDepth )
    ) dataRam (
        .clk ( clk    ),
        .bus ( ramBus )
    );

    smGpio #(
        .gpioWidth ( gpioWidth )
    ) gpio (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .bus        ( gpioBus    ),
        .gpioInput  ( gpioInput  ),
        .gpioOutput ( gpioOutput )
    );

    smPwm #(
        .pwmWidth ( pwmWidth )
    ) pwm (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .bus       ( pwmBus    ),
        .pwmOutput ( pwmOutput )
    );

    // ambient light sensor reader
    smAls #(
        .alsDivider ( alsDivider )
    ) als (
        .clk ( clk    ),
        .rst ( rst    ),
        .bus ( alsBus ),
        .cs  ( alsCS  ),
        .sck ( alsSCK ),
        .sdo ( alsSDO )
    );

endmodule : smMatrix

//--- src/smPwm.sv
`timescale 1ns/100ps

module smPwm #(
    parameter int unsigned pwmWidth = 8
) (
    input  logic   clk,
    input  logic   rst,
    smBusIf.target bus,
    output logic   pwmOutput
);

    logic [pwmWidth-1:0] threshold;  // as written by the bus
    logic [pwmWidth-1:0] shadow;     // threshold in use this period
    logic [pwmWidth-1:0] counter;
    logic                wrap;

    assign wrap = &counter;  // last count of the period

    // bus writes land here, any offset in the window
    always_ff @(posedge clk) begin
        if (rst) begin
            threshold <= '0;
        end else if (bus.sel && bus.write) begin
            threshold <= bus.wData[pwmWidth-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counter   <= '0;
            shadow    <= '0;
            pwmOutput <= 1'b0;
        end else begin
            counter <= counter + 1'b1;  // free running
            if (wrap) begin
                shadow <= threshold;     // new value starts with count 0
            end
            // high for counts below the threshold, one cycle behind the counter
            pwmOutput <= (counter < shadow);
        end
    end

    assign bus.rData = 32'(threshold);

    // the compare value may only move on a period boundary
    shadowAtWrap: assert property (@(posedge clk) disable iff (rst)
        $changed(shadow) |-> (counter == '0))
        else $error("pwm: shadow threshold changed mid-period");

endmodule : smPwm

//--- src/smRam.sv
`timescale 1ns/100ps

module smRam #(
    parameter int unsigned ramDepth = 256
) (
    input  logic   clk,
    smBusIf.target bus
);

    localparam int unsigned idxWidth = (ramDepth > 1) ? $clog2(ramDepth) : 1;

    logic [31:0]         mem [ramDepth];
    logic [idxWidth-1:0] index;

    // word index, byte offset bits dropped, wraps at ramDepth
    assign index = idxWidth'(bus.addr[31:2] % ramDepth);

    always_ff @(posedge clk) begin
        if (bus.sel && bus.write) begin
            mem[index] <= bus.wData;  // full word only
        end
    end

    // asynchronous read port
    assign bus.rData = mem[index];

endmodule : smRam

//--- verilog.f
src/smConfig.sv
src/smBusIf.sv
src/smBusRouter.sv
src/smRam.sv
src/smGpio.sv
src/smPwm.sv
src/smAls.sv
src/smMatrix.sv
bench/alsSensorModel.sv
bench/tbSmMatrix.sv
